// File: list.f
source/soc_pkg.sv
source/bus_decoder.sv
source/int_mem.sv
source/rst_ctr.sv
source/uart_core.sv
source/system.sv
verif/system_tb.sv

// File: boot.hex
// boot image for the internal memory, word 0 first, one 32-bit hex word per line
// bytes from msb: word index, index + 0x40, 0xff - index, 0xc3
0040ffc3
0141fec3
0242fdc3
0343fcc3
0444fbc3
0545fac3
0646f9c3
0747f8c3
0848f7c3
0949f6c3
0a4af5c3
0b4bf4c3
0c4cf3c3
0d4df2c3
0e4ef1c3
0f4ff0c3
1050efc3
1151eec3
1252edc3
1353ecc3
1454ebc3
1555eac3
1656e9c3
1757e8c3
1858e7c3
1959e6c3
1a5ae5c3
1b5be4c3
1c5ce3c3
1d5de2c3
1e5ee1c3
1f5fe0c3
2060dfc3
2161dec3
2262ddc3
2363dcc3
2464dbc3
2565dac3
2666d9c3
2767d8c3
2868d7c3
2969d6c3
2a6ad5c3
2b6bd4c3
2c6cd3c3
2d6dd2c3
2e6ed1c3
2f6fd0c3
3070cfc3
3171cec3
3272cdc3
3373ccc3
3474cbc3
3575cac3
3676c9c3
3777c8c3
3878c7c3
3979c6c3
3a7ac5c3
3b7bc4c3
3c7cc3c3
3d7dc2c3
3e7ec1c3
3f7fc0c3

// File: verif/system_tb.sv
`default_nettype none

module system_tb;

   timeunit 1ns;
   timeprecision 1ns;

   logic                          clk = 1'b0;
   logic                          rst_n;
   logic [soc_pkg::addr_w-1:0]    m_addr;
   logic [soc_pkg::data_w-1:0]    m_wdata;
   logic [soc_pkg::data_w/8-1:0]  m_wstrb;
   logic                          m_valid;
   logic                          uart_rxd;
   logic [soc_pkg::data_w-1:0]    m_rdata;
   logic                          m_ready;
   logic                          busy;
   logic                          uart_txd;

   // reference model
   logic [soc_pkg::data_w-1:0]    image [soc_pkg::boot_words];
   logic [soc_pkg::data_w-1:0]    model_ram [2**soc_pkg::mem_addr_w];
   logic                          model_boot;
   logic [7:0]                    model_rx;

   integer seed = 33;
   int     n_ops = 64;
   int     n_bytes = 8;
   int     checks_ok = 0;
   int     checks_bad = 0;
   int     test_start_bad = 0;

   system DUT (
      .clk(clk), .rst_n(rst_n),
      .m_addr(m_addr), .m_wdata(m_wdata), .m_wstrb(m_wstrb), .m_valid(m_valid),
      .uart_rxd(uart_rxd),
      .m_rdata(m_rdata), .m_ready(m_ready),
      .busy(busy), .uart_txd(uart_txd)
   );

   always #20 clk = ~clk;

   // serial loopback
   assign uart_rxd = uart_txd;

   task automatic note_failure(input string what);
      $display("at %0t ns: %s", $time, what);
      checks_bad++;
   endtask

   task automatic check_word(input string name, input logic [soc_pkg::data_w-1:0] got,
         input logic [soc_pkg::data_w-1:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         checks_bad++;
      end
      else
         checks_ok++;
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
         checks_bad++;
      end
      else
         checks_ok++;
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         checks_bad++;
      end
      else
         checks_ok++;
   endtask

   task automatic finish_test(input string name);
      if (checks_bad == test_start_bad)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, checks_bad - test_start_bad);
      test_start_bad = checks_bad;
   endtask

   function automatic logic [soc_pkg::addr_w-1:0] slot_addr(input int slot, input int word);
      logic [soc_pkg::addr_w-1:0] a;
      a = soc_pkg::addr_w'(word * 4);
      a[soc_pkg::addr_w-1 -: soc_pkg::n_slaves_w] = soc_pkg::n_slaves_w'(slot);
      return a;
   endfunction

   // word the model touches with the boot window mirrored at address zero
   function automatic int phys_word(input int word);
      if (model_boot)
         return soc_pkg::boot_base + word % soc_pkg::boot_words;
      return word;
   endfunction

   function automatic int random_index(input int count);
      return $unsigned($random(seed)) % count;
   endfunction

   function automatic logic [3:0] random_strobe();
      logic [3:0] s;
      s = 4'($random(seed));
      // zero strobes would turn the write into a read
      if (s == 4'h0)
         s = 4'hf;
      return s;
   endfunction

   task automatic reload_model_image();
      for (int i = 0; i < soc_pkg::boot_words; i++)
         model_ram[soc_pkg::boot_base + i] = image[i];
   endtask

   task automatic wait_not_busy();
      int n;
      n = 0;
      @(posedge clk);
      while (busy && n < 4 * (soc_pkg::boot_words + soc_pkg::soft_rst_cycles))
      begin
         @(posedge clk);
         n++;
      end
      if (busy)
         note_failure("busy stayed high, the boot copy never finished");
   endtask

   // one access with valid held until the ready pulse has been seen
   task automatic bus_access(input logic [soc_pkg::addr_w-1:0] addr,
         input logic [soc_pkg::data_w-1:0] wdata, input logic [soc_pkg::data_w/8-1:0] strb,
         output logic [soc_pkg::data_w-1:0] rdata);
      int n;
      wait_not_busy();
      m_addr <= addr;
      m_wdata <= wdata;
      m_wstrb <= strb;
      m_valid <= 1'b1;
      n = 0;
      rdata = 'x;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!m_ready && n < 8);
      if (m_ready)
      begin
         rdata = m_rdata;
         // one clock of latency puts the ready on the second edge
         if (n != 2)
            note_failure($sformatf("m_ready for address %h came on edge %0d instead of edge 2",
               addr, n));
      end
      else
         note_failure($sformatf("no ready came back for the access to address %h", addr));
      m_valid <= 1'b0;
   endtask

   task automatic bus_write(input logic [soc_pkg::addr_w-1:0] addr,
         input logic [soc_pkg::data_w-1:0] data, input logic [soc_pkg::data_w/8-1:0] strb);
      logic [soc_pkg::data_w-1:0] ignored;
      bus_access(addr, data, strb, ignored);
   endtask

   task automatic bus_read(input logic [soc_pkg::addr_w-1:0] addr,
         output logic [soc_pkg::data_w-1:0] data);
      bus_access(addr, '0, '0, data);
   endtask

   task automatic mem_write(input int word, input logic [soc_pkg::data_w-1:0] data,
         input logic [soc_pkg::data_w/8-1:0] strb);
      int p;
      p = phys_word(word);
      for (int b = 0; b < soc_pkg::data_w / 8; b++)
         if (strb[b])
            model_ram[p][8*b +: 8] = data[8*b +: 8];
      bus_write(slot_addr(soc_pkg::mem_slot, word), data, strb);
   endtask

   task automatic mem_check(input int word);
      logic [soc_pkg::data_w-1:0] got;
      bus_read(slot_addr(soc_pkg::mem_slot, word), got);
      check_word($sformatf("m_rdata (memory word %0d)", word), got, model_ram[phys_word(word)]);
   endtask

   // called right after the write to the reset controller
   task automatic watch_soft_reset(output int high_cycles);
      int n;
      n = 0;
      high_cycles = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!busy && n < 8);
      if (!busy)
         note_failure("busy did not rise after the soft reset write");
      while (busy && high_cycles < 4 * soc_pkg::boot_words)
      begin
         high_cycles++;
         @(posedge clk);
      end
   endtask

   task automatic wait_uart_status(input int bit_idx, input logic want, input string what);
      logic [soc_pkg::data_w-1:0] st;
      int tries;
      tries = 0;
      do
      begin
         bus_read(slot_addr(soc_pkg::uart_slot, soc_pkg::reg_status), st);
         tries++;
      end
      while (st[bit_idx] !== want && tries < 10 * soc_pkg::baud_div);
      if (st[bit_idx] !== want)
         note_failure(what);
   endtask

   // rough clock count of all tests at four clocks per bus access
   function automatic int run_estimate();
      int acc;
      int frame;
      int total;
      acc = 4;
      frame = 10 * soc_pkg::baud_div;
      total = 4 + soc_pkg::boot_words + 2 + (soc_pkg::boot_words + 2) * acc;
      total += (n_ops + soc_pkg::boot_words) * acc;
      total += soc_pkg::soft_rst_cycles + 2
               + (2 * 2**soc_pkg::mem_addr_w + soc_pkg::boot_base + 2 * n_ops + 1) * acc;
      total += n_bytes * (2 * frame + 8 * acc);
      total += 10 * acc;
      total += soc_pkg::soft_rst_cycles + soc_pkg::boot_words + 2
               + (soc_pkg::boot_words + 2) * acc;
      return total;
   endfunction

   initial
   begin
      int limit;
      limit = 2 * run_estimate();
      repeat (limit) @(posedge clk);
      $display("watchdog: the run did not end within %0d clocks", limit);
      $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      logic [soc_pkg::data_w-1:0] got;
      logic [7:0]                 tx_byte;
      int                         high_cycles;
      int                         w;

      rst_n = 1'b0;
      m_addr = '0;
      m_wdata = '0;
      m_wstrb = '0;
      m_valid = 1'b0;
      $readmemh("boot.hex", image);
      model_boot = 1'b1;
      model_rx = '0;
      reload_model_image();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // idle outputs and then the image seen at address zero
      @(posedge clk);
      check_bit("busy", busy, 1'b1);
      check_bit("m_ready", m_ready, 1'b0);
      check_bit("uart_txd", uart_txd, 1'b1);
      bus_read(slot_addr(soc_pkg::rst_slot, 0), got);
      check_bit("m_rdata[0] (boot flag)", got[0], 1'b1);
      for (int i = 0; i < soc_pkg::boot_words; i++)
         mem_check(i);
      finish_test("test 1 reset and boot image");

      for (int i = 0; i < n_ops; i++)
      begin
         w = random_index(soc_pkg::boot_words);
         if ($random(seed) & 1)
            mem_write(w, $random(seed), random_strobe());
         else
            mem_check(w);
      end
      for (int i = 0; i < soc_pkg::boot_words; i++)
         mem_check(i);
      finish_test("test 2 boot window traffic");

      bus_write(slot_addr(soc_pkg::rst_slot, 0), 32'h0, 4'hf);
      model_boot = 1'b0;
      watch_soft_reset(high_cycles);
      if (high_cycles >= soc_pkg::boot_words)
         note_failure("busy stayed high for a whole copy with the boot flag low");
      bus_read(slot_addr(soc_pkg::rst_slot, 0), got);
      check_bit("m_rdata[0] (boot flag)", got[0], 1'b0);
      // upper words keep the data written through the boot window
      for (int i = soc_pkg::boot_base; i < 2**soc_pkg::mem_addr_w; i++)
         mem_check(i);
      // lower words were never written since power up
      for (int i = 0; i < soc_pkg::boot_base; i++)
         mem_write(i, $random(seed), 4'hf);
      for (int i = 0; i < 2 * n_ops; i++)
      begin
         w = random_index(2**soc_pkg::mem_addr_w);
         if ($random(seed) & 1)
            mem_write(w, $random(seed), random_strobe());
         else
            mem_check(w);
      end
      for (int i = 0; i < 2**soc_pkg::mem_addr_w; i++)
         mem_check(i);
      finish_test("test 3 soft reset without boot");

      for (int i = 0; i < n_bytes; i++)
      begin
         wait_uart_status(0, 1'b0, "the serial transmitter stayed busy");
         tx_byte = 8'($random(seed));
         bus_write(slot_addr(soc_pkg::uart_slot, soc_pkg::reg_tx_data), {24'h0, tx_byte}, 4'h1);
         model_rx = tx_byte;
         wait_uart_status(1, 1'b1, "no byte arrived through the serial loopback");
         bus_read(slot_addr(soc_pkg::uart_slot, soc_pkg::reg_rx_data), got);
         check_byte("m_rdata[7:0] (rx data)", got[7:0], model_rx);
         bus_read(slot_addr(soc_pkg::uart_slot, soc_pkg::reg_status), got);
         check_bit("m_rdata[1] (rx valid)", got[1], 1'b0);
      end
      finish_test("test 4 serial loopback");

      // slot 3 is unmapped
      bus_read(slot_addr(3, 0), got);
      check_word("m_rdata (unmapped slot)", got, '0);
      for (int i = 0; i < 4; i++)
      begin
         w = random_index(2**soc_pkg::mem_addr_w);
         bus_write(slot_addr(3, w), $random(seed), 4'hf);
         mem_check(w);
         bus_read(slot_addr(3, w), got);
         check_word("m_rdata (unmapped slot)", got, '0);
      end
      finish_test("test 5 unmapped slot");

      bus_write(slot_addr(soc_pkg::rst_slot, 0), 32'h1, 4'hf);
      model_boot = 1'b1;
      reload_model_image();
      watch_soft_reset(high_cycles);
      if (high_cycles != soc_pkg::soft_rst_cycles + soc_pkg::boot_words + 1)
         note_failure($sformatf("busy was high for %0d clocks, expected %0d", high_cycles,
            soc_pkg::soft_rst_cycles + soc_pkg::boot_words + 1));
      bus_read(slot_addr(soc_pkg::rst_slot, 0), got);
      check_bit("m_rdata[0] (boot flag)", got[0], 1'b1);
      for (int i = 0; i < soc_pkg::boot_words; i++)
         mem_check(i);
      finish_test("test 6 soft reset with boot");

      $display("checks passed: %0d, checks failed: %0d", checks_ok, checks_bad);
      if (checks_bad == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/system.sv
`default_nettype none

module system (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [soc_pkg::addr_w-1:0]    m_addr,
   input  logic [soc_pkg::data_w-1:0]    m_wdata,
   input  logic [soc_pkg::data_w/8-1:0]  m_wstrb,
   input  logic                          m_valid,
   input  logic                          uart_rxd,
   output logic [soc_pkg::data_w-1:0]    m_rdata,
   output logic                          m_ready,
   output logic                          busy,
   output logic                          uart_txd
);

   logic                           soft_rst;
   logic                           rst_int_n;
   logic                           boot;
   logic                           write;
   logic [soc_pkg::mem_addr_w-1:0] mem_word;
   logic [2:0]                     s_valid;
   logic [2:0]                     s_ready;
   logic [soc_pkg::data_w-1:0]     s_rdata [3];

   // internal reset, external pin or soft reset pulse
   assign rst_int_n = rst_n && !soft_rst;
   assign write = |m_wstrb;

   bus_decoder decoder0 (
      .clk(clk), .rst_n(rst_int_n), .boot(boot),
      .m_addr(m_addr), .m_valid(m_valid),
      .s_rdata(s_rdata), .s_ready(s_ready),
      .mem_word(mem_word), .s_valid(s_valid),
      .m_rdata(m_rdata), .m_ready(m_ready)
   );

   int_mem int_mem0 (
      .clk(clk), .rst_n(rst_int_n), .boot(boot),
      .mem_word(mem_word), .wdata(m_wdata), .wstrb(m_wstrb),
      .valid(s_valid[soc_pkg::mem_slot]),
      .busy(busy),
      .rdata(s_rdata[soc_pkg::mem_slot]),
      .ready(s_ready[soc_pkg::mem_slot])
   );

   uart_core uart0 (
      .clk(clk), .rst_n(rst_int_n),
      .valid(s_valid[soc_pkg::uart_slot]),
      .write(write),
      .reg_sel(soc_pkg::uart_reg_e'(m_addr[3:2])),
      .wdata(m_wdata[7:0]),
      .rxd(uart_rxd),
      .ready(s_ready[soc_pkg::uart_slot]),
      .rdata(s_rdata[soc_pkg::uart_slot]),
      .txd(uart_txd)
   );

   // runs from the pin reset so the boot flag survives a soft reset
   rst_ctr rst_ctr0 (
      .clk(clk), .rst_n(rst_n),
      .wdata_bit(m_wdata[0]), .write(write),
      .valid(s_valid[soc_pkg::rst_slot]),
      .soft_rst(soft_rst), .boot(boot),
      .rdata(s_rdata[soc_pkg::rst_slot]),
      .ready(s_ready[soc_pkg::rst_slot])
   );

endmodule

`default_nettype wire

// File: source/uart_core.sv
`default_nettype none

module uart_core (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        valid,
   input  logic                        write,
   input  soc_pkg::uart_reg_e          reg_sel,
   input  logic [7:0]                  wdata,
   input  logic                        rxd,
   output logic                        ready,
   output logic [soc_pkg::data_w-1:0]  rdata,
   output logic                        txd
);

   soc_pkg::uart_tx_state_e              tx_state;
   soc_pkg::uart_rx_state_e              rx_state;
   logic [$clog2(soc_pkg::baud_div)-1:0] tx_baud;
   logic [$clog2(soc_pkg::baud_div)-1:0] rx_baud;
   logic [2:0]                           tx_bit;
   logic [2:0]                           rx_bit;
   logic [7:0]                           tx_shift;
   logic [7:0]                           rx_shift;
   logic [7:0]                           rx_byte;
   logic                                 rx_valid;
   logic [1:0]                           rxd_sync;
   logic                                 accept;
   logic                                 tx_go;
   logic                                 rx_read;
   logic                                 tx_tick;
   logic                                 rx_tick;
   logic                                 rx_done;

   assign accept = valid && !ready;
   assign tx_go = accept && write && reg_sel == soc_pkg::reg_tx_data
                  && tx_state == soc_pkg::tx_idle;
   assign rx_read = accept && !write && reg_sel == soc_pkg::reg_rx_data;
   assign tx_tick = tx_baud == soc_pkg::baud_div - 1;
   assign rx_tick = rx_baud == soc_pkg::baud_div - 1;
   assign rx_done = rx_state == soc_pkg::rx_stop && rx_tick && rxd_sync[1];

   // line level straight from the FSM
   assign txd = tx_state == soc_pkg::tx_start ? 1'b0 :
                tx_state == soc_pkg::tx_data ? tx_shift[0] : 1'b1;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tx_state <= soc_pkg::tx_idle;
         tx_baud <= '0;
         tx_bit <= '0;
         tx_shift <= '0;
      end
      else
      begin
         tx_baud <= tx_tick ? '0 : tx_baud + 1'b1;
         case (tx_state)
            soc_pkg::tx_idle:
               if (tx_go)
               begin
                  tx_shift <= wdata;
                  tx_baud <= '0;
                  tx_state <= soc_pkg::tx_start;
               end
            soc_pkg::tx_start:
               if (tx_tick)
               begin
                  tx_bit <= '0;
                  tx_state <= soc_pkg::tx_data;
               end
            soc_pkg::tx_data:
               if (tx_tick)
               begin
                  // lsb first
                  tx_shift <= tx_shift >> 1;
                  tx_bit <= tx_bit + 1'b1;
                  if (tx_bit == 3'd7)
                     tx_state <= soc_pkg::tx_stop;
               end
            default:
               if (tx_tick)
                  tx_state <= soc_pkg::tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rxd_sync <= 2'b11;
         rx_state <= soc_pkg::rx_idle;
         rx_baud <= '0;
         rx_bit <= '0;
         rx_shift <= '0;
      end
      else
      begin
         rxd_sync <= {rxd_sync[0], rxd};
         rx_baud <= rx_tick ? '0 : rx_baud + 1'b1;
         case (rx_state)
            soc_pkg::rx_idle:
               if (!rxd_sync[1])
               begin
                  rx_baud <= '0;
                  rx_state <= soc_pkg::rx_start;
               end
            soc_pkg::rx_start:
               // half a bit in, start bit must still be low
               if (rx_baud == soc_pkg::baud_div / 2 - 1)
               begin
                  rx_baud <= '0;
                  rx_bit <= '0;
                  rx_state <= rxd_sync[1] ? soc_pkg::rx_idle : soc_pkg::rx_data;
               end
            soc_pkg::rx_data:
               if (rx_tick)
               begin
                  rx_shift <= {rxd_sync[1], rx_shift[7:1]};
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7)
                     rx_state <= soc_pkg::rx_stop;
               end
            default:
               if (rx_tick)
                  rx_state <= soc_pkg::rx_idle;
         endcase
      end
   end

   // a fresh byte wins over a read in the same clock
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_valid <= 1'b0;
         ready <= 1'b0;
      end
      else
      begin
         ready <= accept;
         if (rx_done)
            rx_valid <= 1'b1;
         else if (rx_read)
            rx_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_done)
         rx_byte <= rx_shift;
      if (accept)
         case (reg_sel)
            soc_pkg::reg_status:
               rdata <= {{(soc_pkg::data_w-2){1'b0}}, rx_valid, tx_state != soc_pkg::tx_idle};
            soc_pkg::reg_rx_data:
               rdata <= {{(soc_pkg::data_w-8){1'b0}}, rx_byte};
            default:
               rdata <= '0;
         endcase
   end

endmodule

`default_nettype wire

// File: source/rst_ctr.sv
`default_nettype none

module rst_ctr (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wdata_bit,
   input  logic                        write,
   input  logic                        valid,
   output logic                        soft_rst,
   output logic                        boot,
   output logic [soc_pkg::data_w-1:0]  rdata,
   output logic                        ready
);

   logic [$clog2(soc_pkg::soft_rst_cycles)-1:0] cnt;

   // only the external reset reaches this block
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ready <= 1'b0;
         boot <= 1'b1;
         soft_rst <= 1'b0;
         cnt <= '0;
      end
      else
      begin
         ready <= valid && !ready;
         if (valid && !ready && write)
            boot <= wdata_bit;
         // pulse starts once the ready has been seen
         if (ready && write)
         begin
            soft_rst <= 1'b1;
            cnt <= '0;
         end
         else if (soft_rst)
         begin
            cnt <= cnt + 1'b1;
            if (cnt == soc_pkg::soft_rst_cycles - 1)
               soft_rst <= 1'b0;
         end
      end
   end

   assign rdata = {{(soc_pkg::data_w-1){1'b0}}, boot};

endmodule

`default_nettype wire

// File: source/int_mem.sv
`default_nettype none

module int_mem (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            boot,
   input  logic [soc_pkg::mem_addr_w-1:0]  mem_word,
   input  logic [soc_pkg::data_w-1:0]      wdata,
   input  logic [soc_pkg::data_w/8-1:0]    wstrb,
   input  logic                            valid,
   output logic                            busy,
   output logic [soc_pkg::data_w-1:0]      rdata,
   output logic                            ready
);

   logic [soc_pkg::data_w-1:0]           ram [2**soc_pkg::mem_addr_w];
   logic [soc_pkg::data_w-1:0]           rom [soc_pkg::boot_words];
   logic [soc_pkg::data_w-1:0]           rom_q;
   logic [$clog2(soc_pkg::boot_words):0] cnt;
   logic [soc_pkg::mem_addr_w-1:0]       copy_addr;
   logic                                 copy_we;
   logic                                 accept;

   initial $readmemh("boot.hex", rom);

   assign accept = valid && !ready;

   // rom_q trails cnt by one clock, so it belongs to word cnt-1
   assign copy_we = busy && cnt != 0;
   assign copy_addr = soc_pkg::mem_addr_w'(soc_pkg::boot_base + cnt - 1);

   // copy engine, starts as soon as reset is released
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy <= 1'b1;
         cnt <= '0;
      end
      else if (busy)
      begin
         cnt <= cnt + 1'b1;
         // a soft reset with boot low skips the copy
         if (!boot || cnt == soc_pkg::boot_words)
            busy <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ready <= 1'b0;
      else
         ready <= accept;
   end

   always_ff @(posedge clk)
   begin
      rom_q <= rom[cnt[$clog2(soc_pkg::boot_words)-1:0]];
      if (copy_we)
         ram[copy_addr] <= rom_q;
      else if (accept)
      begin
         for (int b = 0; b < soc_pkg::data_w / 8; b++)
            if (wstrb[b])
               ram[mem_word][8*b +: 8] <= wdata[8*b +: 8];
      end
      rdata <= ram[mem_word];
   end

endmodule

`default_nettype wire

// File: source/bus_decoder.sv
`default_nettype none

module bus_decoder (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            boot,
   input  logic [soc_pkg::addr_w-1:0]      m_addr,
   input  logic                            m_valid,
   input  logic [soc_pkg::data_w-1:0]      s_rdata [3],
   input  logic [2:0]                      s_ready,
   output logic [soc_pkg::mem_addr_w-1:0]  mem_word,
   output logic [2:0]                      s_valid,
   output logic [soc_pkg::data_w-1:0]      m_rdata,
   output logic                            m_ready
);

   logic [soc_pkg::n_slaves_w-1:0] slot;
   logic [soc_pkg::mem_addr_w-1:0] word_idx;
   logic                           unmapped;
   logic                           nomap_ready;

   assign slot = m_addr[soc_pkg::addr_w-1 -: soc_pkg::n_slaves_w];
   assign unmapped = slot > soc_pkg::rst_slot;

   // byte address to RAM word
   assign word_idx = m_addr[soc_pkg::mem_addr_w+1:2];

   // while booting, the image region at the top of the RAM is seen at address zero
   assign mem_word = boot ?
      soc_pkg::mem_addr_w'(soc_pkg::boot_base + word_idx % soc_pkg::boot_words) : word_idx;

   always_comb
   begin
      for (int i = 0; i < 3; i++)
         s_valid[i] = m_valid && slot == i;
   end

   // return path, slot 3 answers with zero data
   always_comb
   begin
      if (unmapped)
      begin
         m_ready = nomap_ready;
         m_rdata = '0;
      end
      else
      begin
         m_ready = s_ready[slot];
         m_rdata = s_rdata[slot];
      end
   end

   // one-cycle ready for the empty slot
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         nomap_ready <= 1'b0;
      else
         nomap_ready <= m_valid && unmapped && !nomap_ready;
   end

endmodule

`default_nettype wire

// File: source/soc_pkg.sv
`default_nettype none

package soc_pkg;

   // memory bus
   localparam int unsigned addr_w = 16;
   localparam int unsigned data_w = 32;
   localparam int unsigned n_slaves_w = 2;

   // slot numbers in the top address bits
   localparam int unsigned mem_slot = 0;
   localparam int unsigned uart_slot = 1;
   localparam int unsigned rst_slot = 2;

   // internal memory, boot image sits in the top 64 words
   localparam int unsigned mem_addr_w = 8;
   localparam int unsigned boot_words = 64;
   localparam int unsigned boot_base = 192;

   localparam int unsigned soft_rst_cycles = 4;

   // clocks per serial bit
   localparam int unsigned baud_div = 8;

   typedef enum logic [1:0] {
      reg_tx_data = 2'd0,
      reg_status  = 2'd1,
      reg_rx_data = 2'd2
   } uart_reg_e;

   typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} uart_tx_state_e;
   typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} uart_rx_state_e;

endpackage

`default_nettype wire
